//--- tb.f
+incdir+tb
verilog/rv_pkg.sv
verilog/pc_counter.sv
verilog/ahb_fetch_fsm.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/rv32_core.sv
tb/tb_rv32_core.sv

//--- Makefile
TOP := tb_rv32_core

.PHONY: run build lint clean

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f tb.f

lint:
	verilator --lint-only -Wall --top-module rv32_core \
		verilog/rv_pkg.sv verilog/pc_counter.sv verilog/ahb_fetch_fsm.sv \
		verilog/register_file.sv verilog/decode_stage.sv \
		verilog/execute_stage.sv verilog/rv32_core.sv

clean:
	rm -rf obj_dir

//--- tb/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// row columns are instruction word, retires, expected rd, expected data, test group
// row i sits at byte address 4*i in the slave memory

localparam logic [2:0] GRP_ALU  = 3'd0;                 // plain ALU results
localparam logic [2:0] GRP_FWD  = 3'd1;                 // dependent on a recent result
localparam logic [2:0] GRP_X0   = 3'd2;                 // writes or reads x0
localparam logic [2:0] GRP_NOP  = 3'd3;                 // unknown word, no retire
localparam logic [2:0] GRP_HALT = 3'd4;                 // EBREAK and the word behind it

typedef struct packed {
    rv_pkg::word_t    word;
    logic             retires;                          // row shows up on the retire port
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    data;
    logic [2:0]       group;
} row_t;

localparam int NUM_ROWS = 20;

function automatic row_t program_row(input int i);
    case (i)
        0:  return {32'h00500093, 1'b1, 5'd1,  32'h00000005, GRP_ALU};  // addi x1, x0, 5
        1:  return {32'hFFD00113, 1'b1, 5'd2,  32'hFFFFFFFD, GRP_ALU};  // addi x2, x0, -3
        2:  return {32'h002081B3, 1'b1, 5'd3,  32'h00000002, GRP_FWD};  // add x3, x1, x2
        3:  return {32'h40208233, 1'b1, 5'd4,  32'h00000008, GRP_FWD};  // sub x4, x1, x2
        4:  return {32'h001122B3, 1'b1, 5'd5,  32'h00000001, GRP_ALU};  // slt x5, x2, x1
        5:  return {32'h0020A333, 1'b1, 5'd6,  32'h00000000, GRP_ALU};  // slt x6, x1, x2
        6:  return {32'h0041F3B3, 1'b1, 5'd7,  32'h00000000, GRP_ALU};  // and x7, x3, x4
        7:  return {32'h0041E433, 1'b1, 5'd8,  32'h0000000A, GRP_ALU};  // or x8, x3, x4
        8:  return {32'h001444B3, 1'b1, 5'd9,  32'h0000000F, GRP_FWD};  // xor x9, x8, x1
        9:  return {32'h0064F513, 1'b1, 5'd10, 32'h00000006, GRP_ALU};  // andi x10, x9, 6
        10: return {32'h03056593, 1'b1, 5'd11, 32'h00000036, GRP_ALU};  // ori x11, x10, 0x30
        11: return {32'hFFF5C613, 1'b1, 5'd12, 32'hFFFFFFC9, GRP_ALU};  // xori x12, x11, -1
        12: return {32'h123456B7, 1'b1, 5'd13, 32'h12345000, GRP_ALU};  // lui x13, 0x12345
        13: return {32'h67868693, 1'b1, 5'd13, 32'h12345678, GRP_FWD};  // addi x13, x13, 0x678
        14: return {32'h00708013, 1'b1, 5'd0,  32'h0000000C, GRP_X0};   // addi x0, x1, 7
        15: return {32'h00100733, 1'b1, 5'd14, 32'h00000005, GRP_X0};   // add x14, x0, x1
        16: return {32'h00000000, 1'b0, 5'd0,  32'h00000000, GRP_NOP};  // not an RV32I op
        17: return {32'h00E687B3, 1'b1, 5'd15, 32'h1234567D, GRP_FWD};  // add x15, x13, x14
        18: return {32'h00100073, 1'b0, 5'd0,  32'h00000000, GRP_HALT}; // ebreak
        19: return {32'h00100813, 1'b0, 5'd16, 32'h00000001, GRP_HALT}; // addi x16, x0, 1
        default: return '0;
    endcase
endfunction

`endif

//--- tb/tb_rv32_core.sv
`default_nettype none

module tb_rv32_core;

    `include "tb_program.svh"

    localparam int NUM_RUNS        = 2;                 // run 0 zero wait, run 1 lfsr waits
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 16 + 100;
    localparam int HALT_WINDOW     = 32;                // cycles watched once halted is up

    logic            clk;
    logic            rst;
    logic            hready;
    rv_pkg::word_t   hrdata;
    rv_pkg::word_t   haddr;
    rv_pkg::htrans_t htrans;
    rv_pkg::retire_t retire;
    logic            halted;

    logic            rst_req;                           // main to driver, moved on rising edges
    logic            use_lfsr;
    logic [15:0]     lfsr;
    logic            dp_valid;                          // slave data phase in progress
    rv_pkg::word_t   dp_addr;
    rv_pkg::word_t   exp_addr;                          // next address the core should issue
    logic            last_wait;                         // last cycle held an address, hready low
    rv_pkg::word_t   last_addr;
    int              bus_errors;
    int              tests_passed;
    int              tests_failed;

    rv32_core UUT (
        .clk    (clk),
        .rst    (rst),
        .hready (hready),
        .hrdata (hrdata),
        .haddr  (haddr),
        .htrans (htrans),
        .retire (retire),
        .halted (halted)
    );

    always #2 clk = ~clk;

    // galois lfsr, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // memory past the program holds addi x17 with an address-derived immediate
    function automatic rv_pkg::word_t mem_word(input rv_pkg::word_t addr);
        row_t        r;
        logic [11:0] imm;
        imm = addr[13:2] ^ addr[25:14] ^ {6'd0, addr[31:26]};
        r   = program_row(int'(addr[31:2]));
        if (addr[31:2] < NUM_ROWS) begin
            return r.word;
        end
        return {imm, 5'd0, 3'b000, 5'd17, 7'b0010011};
    endfunction

    function automatic string group_name(input logic [2:0] g);
        case (g)
            GRP_ALU: return "alu";
            GRP_FWD: return "fwd";
            GRP_X0:  return "x0";
            GRP_NOP: return "nop";
            default: return "halt";
        endcase
    endfunction

    function automatic int next_retiring(input int from);
        row_t r;
        for (int i = from; i < NUM_ROWS; i++) begin
            r = program_row(i);
            if (r.retires) return i;
        end
        return NUM_ROWS;                                // nothing left to retire
    endfunction

    // falling edge, drive rst and the slave side of the bus
    always @(negedge clk) begin
        rst = rst_req;
        if (rst_req) begin
            hready    = 1'b1;
            hrdata    = '0;
            dp_valid  = 1'b0;
            exp_addr  = 32'h0;                          // first fetch at address zero
            last_wait = 1'b0;
        end else begin
            if (use_lfsr) begin
                hready = lfsr[0];                       // one bit per cycle
                lfsr   = lfsr_next(lfsr);
            end else begin
                hready = 1'b1;
            end
            hrdata = dp_valid ? mem_word(dp_addr) : '0; // data of the phase now in flight
            if (last_wait && haddr != last_addr) begin
                $display("Error at time %0t: haddr moved from %h to %h in a wait state",
                         $time, last_addr, haddr);
                bus_errors++;
            end
            if (htrans == rv_pkg::HTRANS_NONSEQ && hready) begin
                if (haddr != exp_addr) begin
                    $display("Error at time %0t: accepted haddr %h, expected %h",
                             $time, haddr, exp_addr);
                    bus_errors++;
                end
                exp_addr = exp_addr + 32'd4;
            end
            if (hready) begin
                dp_valid = (htrans == rv_pkg::HTRANS_NONSEQ);   // accepted on the next edge
                dp_addr  = haddr;
            end
            last_wait = (htrans == rv_pkg::HTRANS_NONSEQ) && !hready;
            last_addr = haddr;
        end
    end

    task automatic report(input int run, input string name, input int errs);
        if (errs == 0) begin
            tests_passed++;
            $display("run %0d %s: pass", run, name);
        end else begin
            tests_failed++;
            $display("run %0d %s: FAIL with %0d errors", run, name, errs);
        end
    endtask

    task automatic reset_and_check(input int run, input logic lfsr_mode);
        int errs;
        errs = 0;
        @(posedge clk);
        rst_req    = 1'b1;
        use_lfsr   = lfsr_mode;
        bus_errors = 0;
        @(negedge clk);                                 // rst rises here
        for (int k = 1; k <= 3; k++) begin
            if (k == 3) begin
                @(posedge clk);
                rst_req = 1'b0;                         // third reset edge still sees rst
            end
            @(negedge clk);
            if (htrans != rv_pkg::HTRANS_IDLE || retire.valid || halted) begin
                $display("Error at time %0t: htrans %b retire.valid %b halted %b in reset",
                         $time, htrans, retire.valid, halted);
                errs++;
            end
        end
        @(negedge clk);
        if (htrans != rv_pkg::HTRANS_NONSEQ || haddr != 32'h0) begin
            $display("Error at time %0t: first transfer htrans %b haddr %h, expected NONSEQ at 0",
                     $time, htrans, haddr);
            errs++;
        end
        report(run, "reset", errs);
    endtask

    // each valid retire is matched against the next retiring row
    task automatic walk_retires(input int run);
        int   row;
        int   errs;
        row_t exp;
        row = next_retiring(0);
        while (row < NUM_ROWS) begin
            @(negedge clk);
            if (retire.valid) begin
                exp  = program_row(row);
                errs = 0;
                if (retire.rd != exp.rd || retire.data != exp.data) begin
                    $display("Error at time %0t: row %0d retired x%0d = %h, expected x%0d = %h",
                             $time, row, retire.rd, retire.data, exp.rd, exp.data);
                    errs = 1;
                end
                report(run, $sformatf("row %0d %s", row, group_name(exp.group)), errs);
                row = next_retiring(row + 1);
            end
        end
    endtask

    task automatic check_halt(input int run);
        int errs;
        errs = 0;
        while (!halted) begin                           // watchdog catches a core that never halts
            @(negedge clk);
            if (retire.valid) begin
                $display("Error at time %0t: x%0d = %h retired after the last expected row",
                         $time, retire.rd, retire.data);
                errs++;
            end
        end
        repeat (HALT_WINDOW) begin
            @(negedge clk);
            if (!halted || htrans != rv_pkg::HTRANS_IDLE) begin
                $display("Error at time %0t: halted %b htrans %b after EBREAK",
                         $time, halted, htrans);
                errs++;
            end
            if (retire.valid) begin
                $display("Error at time %0t: x%0d = %h retired after EBREAK",
                         $time, retire.rd, retire.data);
                errs++;
            end
        end
        report(run, "halt", errs);
        @(posedge clk);                                 // driver counts settle on falling edges
        report(run, "bus", bus_errors);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        rst_req      = 1'b1;
        use_lfsr     = 1'b0;
        lfsr         = 16'd17;
        hready       = 1'b1;
        hrdata       = '0;
        dp_valid     = 1'b0;
        dp_addr      = '0;
        exp_addr     = '0;
        last_wait    = 1'b0;
        last_addr    = '0;
        bus_errors   = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int run = 0; run < NUM_RUNS; run++) begin
            reset_and_check(run, run != 0);
            walk_retires(run);
            check_halt(run);
        end
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: retires stopped, run still open after %0d cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/rv32_core.sv
`default_nettype none

module rv32_core (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          hready,          // AHB-Lite slave ready
    input  wire rv_pkg::word_t hrdata,          // AHB-Lite read data
    output rv_pkg::word_t      haddr,
    output rv_pkg::htrans_t    htrans,
    output rv_pkg::retire_t    retire,          // one record per written-back instruction
    output logic               halted           // EBREAK reached
);

    logic             advance;                  // fsm -> pc, address accepted
    logic             fetch_valid;              // fsm -> decode
    rv_pkg::word_t    fetch_word;
    logic             ebreak;                   // decode -> fsm
    rv_pkg::reg_idx_t rs1;                      // decode -> register file
    rv_pkg::reg_idx_t rs2;
    rv_pkg::word_t    rdata1;                   // register file -> decode
    rv_pkg::word_t    rdata2;
    rv_pkg::decoded_t dec;                      // decode -> execute

    pc_counter u_pc (
        .clk     (clk),
        .rst     (rst),
        .advance (advance),
        .pc      (haddr)                        // counter drives the bus address directly
    );

    ahb_fetch_fsm u_fetch (
        .clk         (clk),
        .rst         (rst),
        .hready      (hready),
        .hrdata      (hrdata),
        .ebreak      (ebreak),
        .htrans      (htrans),
        .advance     (advance),
        .fetch_valid (fetch_valid),
        .fetch_word  (fetch_word),
        .halted      (halted)
    );

    register_file u_regs (
        .clk    (clk),
        .rst    (rst),
        .rs1    (rs1),
        .rs2    (rs2),
        .wr     (retire),                       // writeback shares the retire record
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    decode_stage u_decode (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_word  (fetch_word),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .rs1         (rs1),
        .rs2         (rs2),
        .ebreak      (ebreak),
        .dec         (dec)
    );

    execute_stage u_execute (
        .clk    (clk),
        .rst    (rst),
        .dec    (dec),
        .retire (retire)
    );

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`default_nettype none

module execute_stage (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire rv_pkg::decoded_t dec,          // decode/execute register
    output rv_pkg::retire_t       retire        // writeback register, also the RF write port
);

    logic            fwd_a;                     // rs1 produced by the previous instruction
    logic            fwd_b;
    rv_pkg::word_t   op_a;
    rv_pkg::word_t   rs2_val;
    rv_pkg::word_t   op_b;
    rv_pkg::word_t   result;
    rv_pkg::retire_t retire_next;

    // the register file read happened one cycle too early for the
    // instruction right before, so its result comes from the writeback register
    assign fwd_a = retire.valid && (retire.rd != '0) && (retire.rd == dec.rs1);
    assign fwd_b = retire.valid && (retire.rd != '0) && (retire.rd == dec.rs2);

    assign op_a    = fwd_a ? retire.data : dec.a;
    assign rs2_val = fwd_b ? retire.data : dec.b;
    assign op_b    = dec.use_imm ? dec.imm : rs2_val; // immediate forms ignore rs2

    always_comb begin
        case (dec.alu_op)
            rv_pkg::ALU_ADD:    result = op_a + op_b;
            rv_pkg::ALU_SUB:    result = op_a - op_b;
            rv_pkg::ALU_AND:    result = op_a & op_b;
            rv_pkg::ALU_OR:     result = op_a | op_b;
            rv_pkg::ALU_XOR:    result = op_a ^ op_b;
            rv_pkg::ALU_SLT:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_PASS_B: result = op_b;  // LUI
            default:            result = '0;
        endcase
    end

    assign retire_next.valid = dec.valid && dec.writes_rd; // bubbles retire nothing
    assign retire_next.rd    = dec.rd;
    assign retire_next.data  = result;

    always_ff @(posedge clk) begin
        if (rst) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= retire_next.valid;
        end
        retire.rd   <= retire_next.rd;
        retire.data <= retire_next.data;
    end

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`default_nettype none

module decode_stage (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          fetch_valid,     // new word from the bus this cycle
    input  wire rv_pkg::word_t fetch_word,
    input  wire rv_pkg::word_t rdata1,          // register file, read combinationally
    input  wire rv_pkg::word_t rdata2,
    output rv_pkg::reg_idx_t   rs1,
    output rv_pkg::reg_idx_t   rs2,
    output logic               ebreak,          // halt request to the fetch sequencer
    output rv_pkg::decoded_t   dec              // decode/execute register
);

    logic             fd_valid;                 // fetch/decode register
    rv_pkg::word_t    fd_word;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             f7_zero;                  // plain funct7, no SUB flag
    rv_pkg::word_t    imm_i;
    rv_pkg::word_t    imm_u;
    logic             known;                    // word is one of the kept instructions
    rv_pkg::decoded_t d;

    // no back-pressure here, a cycle without a word becomes a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            fd_valid <= 1'b0;
        end else begin
            fd_valid <= fetch_valid;
        end
        if (fetch_valid) begin
            fd_word <= fetch_word;
        end
    end

    assign opcode  = fd_word[6:0];
    assign funct3  = fd_word[14:12];
    assign funct7  = fd_word[31:25];
    assign f7_zero = (funct7 == 7'h00);
    assign rs1     = fd_word[19:15];            // straight to the register file
    assign rs2     = fd_word[24:20];
    assign imm_i   = {{20{fd_word[31]}}, fd_word[31:20]}; // sign extended 12 bits
    assign imm_u   = {fd_word[31:12], 12'h000};
    assign ebreak  = fd_valid && (fd_word == rv_pkg::EBREAK_WORD);

    always_comb begin
        d        = '0;
        d.rd     = fd_word[11:7];
        d.rs1    = rs1;
        d.rs2    = rs2;
        d.a      = rdata1;
        d.b      = rdata2;
        d.alu_op = rv_pkg::ALU_ADD;
        known    = 1'b0;
        case (opcode)
            rv_pkg::OPC_OP: begin
                case (funct3)
                    3'b000: begin
                        known    = f7_zero || (funct7 == 7'h20); // ADD or SUB
                        d.alu_op = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    end
                    3'b010: begin known = f7_zero; d.alu_op = rv_pkg::ALU_SLT; end
                    3'b100: begin known = f7_zero; d.alu_op = rv_pkg::ALU_XOR; end
                    3'b110: begin known = f7_zero; d.alu_op = rv_pkg::ALU_OR;  end
                    3'b111: begin known = f7_zero; d.alu_op = rv_pkg::ALU_AND; end
                    default: known = 1'b0;       // shifts and SLTU not kept
                endcase
            end
            rv_pkg::OPC_OP_IMM: begin
                d.use_imm = 1'b1;
                d.imm     = imm_i;
                case (funct3)
                    3'b000: begin known = 1'b1; d.alu_op = rv_pkg::ALU_ADD; end
                    3'b100: begin known = 1'b1; d.alu_op = rv_pkg::ALU_XOR; end
                    3'b110: begin known = 1'b1; d.alu_op = rv_pkg::ALU_OR;  end
                    3'b111: begin known = 1'b1; d.alu_op = rv_pkg::ALU_AND; end
                    default: known = 1'b0;       // SLTI and shifts not kept
                endcase
            end
            rv_pkg::OPC_LUI: begin
                known     = 1'b1;
                d.use_imm = 1'b1;
                d.imm     = imm_u;
                d.alu_op  = rv_pkg::ALU_PASS_B;
            end
            default: known = 1'b0;               // EBREAK lands here too and never retires
        endcase
        d.valid     = fd_valid && known;
        d.writes_rd = known;                     // every kept op writes rd
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= d.valid;
        end
        dec.writes_rd <= d.writes_rd;
        dec.rd        <= d.rd;
        dec.rs1       <= d.rs1;
        dec.rs2       <= d.rs2;
        dec.use_imm   <= d.use_imm;
        dec.imm       <= d.imm;
        dec.alu_op    <= d.alu_op;
        dec.a         <= d.a;
        dec.b         <= d.b;
    end

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`default_nettype none

module register_file (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire rv_pkg::reg_idx_t rs1,
    input  wire rv_pkg::reg_idx_t rs2,
    input  wire rv_pkg::retire_t wr,            // writeback record from execute
    output rv_pkg::word_t        rdata1,
    output rv_pkg::word_t        rdata2
);

    rv_pkg::word_t regs [1:rv_pkg::NUM_REGS-1]; // x0 has no storage
    logic          wr_en;

    assign wr_en = wr.valid && (wr.rd != '0);   // writes to x0 are lost

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // write-through, decode sees the value being written back this cycle
    assign rdata1 = (rs1 == '0) ? '0 : ((wr_en && wr.rd == rs1) ? wr.data : regs[rs1]);
    assign rdata2 = (rs2 == '0) ? '0 : ((wr_en && wr.rd == rs2) ? wr.data : regs[rs2]);

endmodule

`default_nettype wire

//--- verilog/ahb_fetch_fsm.sv
`default_nettype none

module ahb_fetch_fsm (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          hready,          // slave ready, ends address and data phases
    input  wire rv_pkg::word_t hrdata,          // read data of the pending data phase
    input  wire logic          ebreak,          // EBREAK sitting in fetch/decode
    output rv_pkg::htrans_t    htrans,
    output logic               advance,         // to pc_counter, address accepted
    output logic               fetch_valid,     // fetch_word is a new instruction
    output rv_pkg::word_t      fetch_word,
    output logic               halted
);

    rv_pkg::fetch_state_e state;                // sequencer state
    rv_pkg::fetch_state_e state_next;
    logic                 addr_phase;           // NONSEQ driven this cycle
    logic                 data_pending;         // a data phase is in flight

    always_comb begin
        state_next = state;
        case (state)
            rv_pkg::IDLE:   state_next = rv_pkg::FETCH;     // start right after the quiet cycle
            rv_pkg::FETCH:  if (ebreak) state_next = rv_pkg::HALTED;
            rv_pkg::HALTED: state_next = rv_pkg::HALTED;    // only reset leaves
            default:        state_next = rv_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rv_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // the address phase stays up through the ebreak cycle so a transfer
    // already waiting on hready is never withdrawn
    assign addr_phase = (state == rv_pkg::FETCH);
    assign htrans     = addr_phase ? rv_pkg::HTRANS_NONSEQ : rv_pkg::HTRANS_IDLE;
    assign advance    = addr_phase && hready;   // slave samples address on this edge

    // pipelined bus, an accepted address becomes the next data phase
    always_ff @(posedge clk) begin
        if (rst) begin
            data_pending <= 1'b0;
        end else if (hready) begin
            data_pending <= addr_phase;         // previous data phase ends together with it
        end
    end

    // words after the EBREAK are dropped, including one landing in the ebreak cycle
    assign fetch_valid = data_pending && hready && addr_phase && !ebreak;
    assign fetch_word  = hrdata;                // sampled by decode only with fetch_valid
    assign halted      = (state == rv_pkg::HALTED);

endmodule

`default_nettype wire

//--- verilog/pc_counter.sv
`default_nettype none

module pc_counter (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          advance,         // address phase accepted this cycle
    output rv_pkg::word_t      pc               // address presented on the bus
);

    // the bus address only moves once the slave has taken it,
    // so a wait state leaves haddr stable as AHB requires
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= rv_pkg::RESET_PC;             // restart at the reset vector
        end else if (advance) begin
            pc <= pc + rv_pkg::PC_STEP;         // next sequential word
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;                    // data word, instruction or byte address
    typedef logic [4:0]  reg_idx_t;                 // architectural register index
    typedef logic [1:0]  htrans_t;                  // AHB transfer type

    localparam htrans_t HTRANS_IDLE   = 2'b00;      // no transfer this cycle
    localparam htrans_t HTRANS_NONSEQ = 2'b10;      // single word read

    localparam word_t RESET_PC = 32'h0000_0000;     // first fetch address
    localparam word_t PC_STEP  = 32'd4;             // one word per instruction
    localparam int    NUM_REGS = 32;                // x0 .. x31

    // major opcodes still decoded by the core
    localparam logic [6:0] OPC_OP     = 7'b0110011; // register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // register-immediate ALU
    localparam logic [6:0] OPC_LUI    = 7'b0110111; // load upper immediate
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011; // only EBREAK is honoured

    localparam word_t EBREAK_WORD = 32'h0010_0073;  // full encoding, no other SYSTEM word

    typedef enum logic [2:0] {
        ALU_ADD,                                    // a + b
        ALU_SUB,                                    // a - b
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,                                    // signed compare, 0 or 1
        ALU_PASS_B                                  // b straight through, used by LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        IDLE,                                       // one quiet cycle after reset
        FETCH,                                      // issuing a read every accepted cycle
        HALTED                                      // EBREAK seen, bus parked until reset
    } fetch_state_e;

    typedef struct packed {
        logic     valid;                            // record holds a kept instruction
        logic     writes_rd;                        // result goes to rd
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     use_imm;                          // b comes from imm, not from rs2
        word_t    imm;                              // I- or U-type immediate, already extended
        alu_op_e  alu_op;
        word_t    a;                                // rs1 value as read in decode
        word_t    b;                                // rs2 value as read in decode
    } decoded_t;

    typedef struct packed {
        logic     valid;                            // write rd this cycle
        reg_idx_t rd;
        word_t    data;
    } retire_t;

endpackage

`default_nettype wire
